//--- design/brisc_pkg.sv
`default_nettype none

package brisc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register file
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned REG_IDX_W = 5;  // 32 architectural registers.

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pipeline encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // source of the value a stage will write back
  typedef enum logic [1:0] {
    FROM_ALU   = 2'd0,  // plain alu result.
    FROM_CACHE = 2'd1,  // load, data arrives from the dcache.
    FROM_MUL   = 2'd2,  // multiplier pipeline.
    FROM_PC    = 2'd3   // link value, pc + 4.
  } result_src_e;

  // next pc selection
  typedef enum logic {
    FROM_F = 1'b0,  // sequential fetch.
    FROM_A = 1'b1   // branch or jump resolved in the alu stage.
  } pc_src_e;

  // exception cause seen in writeback
  typedef enum logic [1:0] {
    NO_XCPT       = 2'd0,
    ILLEGAL_INSTR = 2'd1,  // decode could not map the opcode.
    LOAD_FAULT    = 2'd2,  // bad load address.
    STORE_FAULT   = 2'd3   // bad store address.
  } xcpt_e;

endpackage

`default_nettype wire

//--- design/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand fields per stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // source registers read in decode
  typedef struct packed {
    brisc_pkg::reg_idx_t rs1;
    brisc_pkg::reg_idx_t rs2;
  } dec_fields_t;

  // destination and control of the instruction in the alu stage
  typedef struct packed {
    brisc_pkg::reg_idx_t    rd;
    brisc_pkg::result_src_e result_src;  // FROM_CACHE marks a load.
    brisc_pkg::pc_src_e     pc_src;
  } alu_fields_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-stage control vectors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a stalled stage holds its pipeline register
  typedef struct packed {
    logic f;  // fetch.
    logic d;  // decode.
    logic a;  // alu.
    logic c;  // cache.
  } stage_stall_t;

  // a flushed stage loads a bubble
  typedef struct packed {
    logic d;
    logic a;
    logic c;
    logic wb;
  } stage_flush_t;

endpackage

`default_nettype wire

//--- design/load_use_check.sv
`timescale 1ns/1ps
`default_nettype none

// Flags a decode-stage instruction that reads the destination of a load
// which is still in the alu stage. The loaded value only exists after the
// cache stage, so decode has to wait one cycle.
module load_use_check (
  input  pipe_ctrl_pkg::dec_fields_t dec,
  input  pipe_ctrl_pkg::alu_fields_t alu,
  output logic                       load_stall
);

  logic is_load;
  logic rs1_hit;
  logic rs2_hit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign is_load = (alu.result_src == brisc_pkg::FROM_CACHE);  // only loads matter.

  // x0 is compared like any other index.
  assign rs1_hit = (dec.rs1 == alu.rd);
  assign rs2_hit = (dec.rs2 == alu.rd);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    load_stall = 1'b0;
    if (is_load) begin
      load_stall = rs1_hit | rs2_hit;  // either operand is enough.
    end
  end

endmodule

`default_nettype wire

//--- design/mul_tracker.sv
`timescale 1ns/1ps
`default_nettype none

// Keeps one valid bit per multiplier pipeline stage. A multiply enters at
// bit 0 on the edge that samples mul_issue, moves up one bit per edge and
// drops out after MUL_DELAY edges. The multiplier cannot be stalled, so the
// bits move on every edge.
module mul_tracker #(
  parameter int unsigned MUL_DELAY = 3
) (
  input  logic clk,
  input  logic rst_n,
  input  logic mul_issue,
  output logic mul_busy
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // valid shift register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [MUL_DELAY-1:0] valid_q;
  logic [MUL_DELAY-1:0] valid_d;
  logic [MUL_DELAY-1:0] issue_bit;

  assign issue_bit = MUL_DELAY'(mul_issue);  // new multiply lands in bit 0.

  always_comb begin
    valid_d = valid_q << 1;  // top bit leaves the pipeline.
    valid_d = valid_d | issue_bit;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // occupancy
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // busy while any stage still holds a multiply. One isolated issue gives
  // exactly MUL_DELAY busy cycles.
  assign mul_busy = |valid_q;

endmodule

`default_nettype wire

//--- design/hazard.sv
`timescale 1ns/1ps
`default_nettype none

// Turns the hazard sources into per-stage stall and flush levels. Stalls
// hold the stages up to the blocking one, flushes insert bubbles behind a
// stage that cannot advance or behind a redirect.
module hazard (
  input  logic                        load_stall,
  input  logic                        mul_busy,
  input  logic                        icache_ready,
  input  logic                        dcache_ready,
  input  logic                        pred_wrong,
  input  brisc_pkg::pc_src_e          alu_pc_src,
  input  brisc_pkg::xcpt_e            xcpt,
  output pipe_ctrl_pkg::stage_stall_t stall,
  output pipe_ctrl_pkg::stage_flush_t flush
);

  logic icache_miss;
  logic dcache_miss;
  logic taken;
  logic excp;
  logic redirect;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decoded conditions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign icache_miss = ~icache_ready;
  assign dcache_miss = ~dcache_ready;
  assign taken       = (alu_pc_src == brisc_pkg::FROM_A);  // resolved in alu.
  assign excp        = (xcpt != brisc_pkg::NO_XCPT);

  // a wrong prediction or a trap drops the front end no matter the caches.
  assign redirect = pred_wrong | excp;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stalls
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    stall = '0;

    // fetch waits on everything downstream and on its own cache.
    stall.f = load_stall | icache_miss | dcache_miss | mul_busy;

    stall.d = load_stall | dcache_miss | mul_busy;  // load-use holds decode.
    stall.a = dcache_miss | mul_busy;
    stall.c = dcache_miss;  // cache stage waits for its data.
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flushes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    flush = '0;

    // a dcache miss freezes the pipe, so taken and load bubbles wait.
    flush.d = ((taken | icache_miss) & dcache_ready) | redirect;
    flush.a = ((taken | load_stall) & dcache_ready) | redirect;

    flush.c  = mul_busy | excp;     // bubble behind the busy multiplier.
    flush.wb = dcache_miss | excp;  // nothing retires during a miss.
  end

endmodule

`default_nettype wire

//--- design/pipe_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

// Hazard control of the five-stage core. Load-use detection and multiply
// tracking run side by side and feed the resolver, which also sees the
// cache levels, the redirect and the writeback exception.
module pipe_ctrl_top #(
  parameter int unsigned MUL_DELAY = 3
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  pipe_ctrl_pkg::dec_fields_t  dec,
  input  pipe_ctrl_pkg::alu_fields_t  alu,
  input  logic                        mul_issue,
  input  logic                        icache_ready,
  input  logic                        dcache_ready,
  input  logic                        pred_wrong,
  input  brisc_pkg::xcpt_e            xcpt,
  output pipe_ctrl_pkg::stage_stall_t stall,
  output pipe_ctrl_pkg::stage_flush_t flush
);

  logic load_stall;
  logic mul_busy;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // hazard sources
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  load_use_check i_load_use (
    .dec        (dec),
    .alu        (alu),
    .load_stall (load_stall)
  );

  mul_tracker #(
    .MUL_DELAY (MUL_DELAY)
  ) i_mul_tracker (
    .clk       (clk),
    .rst_n     (rst_n),
    .mul_issue (mul_issue),
    .mul_busy  (mul_busy)  // registered, lags mul_issue by one edge.
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // resolution
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  hazard i_hazard (
    .load_stall   (load_stall),
    .mul_busy     (mul_busy),
    .icache_ready (icache_ready),
    .dcache_ready (dcache_ready),
    .pred_wrong   (pred_wrong),
    .alu_pc_src   (alu.pc_src),
    .xcpt         (xcpt),
    .stall        (stall),
    .flush        (flush)
  );

endmodule

`default_nettype wire

//--- verif/pipe_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Reference model of the hazard rules. It watches the DUT ports, keeps its
// own multiplier history and compares stall and flush on every rising edge
// while a test runs.
module pipe_ctrl_checker #(
  parameter int unsigned MUL_DELAY = 3
) (
  input logic                        clk,
  input logic                        rst_n,
  input pipe_ctrl_pkg::dec_fields_t  dec,
  input pipe_ctrl_pkg::alu_fields_t  alu,
  input logic                        mul_issue,
  input logic                        icache_ready,
  input logic                        dcache_ready,
  input logic                        pred_wrong,
  input brisc_pkg::xcpt_e            xcpt,
  input pipe_ctrl_pkg::stage_stall_t stall,
  input pipe_ctrl_pkg::stage_flush_t flush
);

  string cur_name;
  logic  running;
  int    cur_checks;
  int    cur_errors;
  int    tests_passed;
  int    tests_failed;
  int    total_errors;

  logic [MUL_DELAY-1:0] mul_hist;  // bit i set when a multiply sits in stage i.
  logic busy;
  logic load_hit;
  logic imiss;
  logic dmiss;
  logic taken;
  logic excp;

  pipe_ctrl_pkg::stage_stall_t exp_stall;
  pipe_ctrl_pkg::stage_flush_t exp_flush;

  initial begin
    cur_name     = "none";
    running      = 1'b0;
    cur_checks   = 0;
    cur_errors   = 0;
    tests_passed = 0;
    tests_failed = 0;
    total_errors = 0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    busy     = (mul_hist != '0);
    load_hit = (alu.result_src == brisc_pkg::FROM_CACHE) &&
               ((dec.rs1 == alu.rd) || (dec.rs2 == alu.rd));
    imiss    = !icache_ready;
    dmiss    = !dcache_ready;
    taken    = (alu.pc_src == brisc_pkg::FROM_A);
    excp     = (xcpt != brisc_pkg::NO_XCPT);

    exp_stall.c = dmiss;
    exp_stall.a = dmiss || busy;
    exp_stall.d = exp_stall.a || load_hit;
    exp_stall.f = exp_stall.d || imiss;

    // redirect terms wait while the dcache misses.
    exp_flush.d = dcache_ready ? (taken || imiss || pred_wrong || excp) : (pred_wrong || excp);
    exp_flush.a = dcache_ready ? (taken || load_hit || pred_wrong || excp) : (pred_wrong || excp);
    exp_flush.c = busy || excp;
    exp_flush.wb = dmiss || excp;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      mul_hist <= '0;
    end else begin
      mul_hist[0] <= mul_issue;  // sampled issue enters the first stage.
      for (int i = 1; i < MUL_DELAY; i++) begin
        mul_hist[i] <= mul_hist[i-1];
      end
      if (running) begin
        compare_outputs();
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bookkeeping
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic compare_outputs();
    cur_checks = cur_checks + 1;
    if ({stall, flush} !== {exp_stall, exp_flush}) begin
      cur_errors = cur_errors + 1;
      $display("FAIL %s at %0d ns: expected stall=%b flush=%b, actual stall=%b flush=%b",
               cur_name, $time, exp_stall, exp_flush, stall, flush);
    end
  endtask

  task automatic start_test(input string name);
    cur_name   = name;
    cur_checks = 0;
    cur_errors = 0;
    running    = 1'b1;
  endtask

  task automatic end_test();
    running      = 1'b0;
    total_errors = total_errors + cur_errors;
    if (cur_errors == 0 && cur_checks > 0) begin
      tests_passed = tests_passed + 1;
      $display("test %-18s %5d cycles checked, ok", cur_name, cur_checks);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %-18s %5d cycles checked, %0d mismatches, failed",
               cur_name, cur_checks, cur_errors);
    end
  endtask

  task automatic report_counts();
    $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
             tests_passed, tests_failed, total_errors);
  endtask

endmodule

`default_nettype wire

//--- verif/tb_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ctrl;

  localparam int unsigned MUL_DELAY = 3;
  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 3;
  localparam int WATCHDOG_MARGIN = 50;  // cycles.
  localparam logic [31:0] SEED = 32'he6e4_037e;

  // length of a test and the chance of each event in percent
  typedef struct packed {
    int cycles;
    int imiss;
    int dmiss;
    int load;
    int match;
    int mul;
    int taken;
    int pred;
    int xcpt;
  } test_cfg_t;

  logic                        clk;
  logic                        rst_n;
  pipe_ctrl_pkg::dec_fields_t  dec;
  pipe_ctrl_pkg::alu_fields_t  alu;
  logic                        mul_issue;
  logic                        icache_ready;
  logic                        dcache_ready;
  logic                        pred_wrong;
  brisc_pkg::xcpt_e            xcpt;
  pipe_ctrl_pkg::stage_stall_t stall;
  pipe_ctrl_pkg::stage_flush_t flush;

  logic [31:0] lcg_state;
  test_cfg_t   cfg_q[$];
  string       name_q[$];

  pipe_ctrl_top #(
    .MUL_DELAY (MUL_DELAY)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec          (dec),
    .alu          (alu),
    .mul_issue    (mul_issue),
    .icache_ready (icache_ready),
    .dcache_ready (dcache_ready),
    .pred_wrong   (pred_wrong),
    .xcpt         (xcpt),
    .stall        (stall),
    .flush        (flush)
  );

  pipe_ctrl_checker #(
    .MUL_DELAY (MUL_DELAY)
  ) i_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec          (dec),
    .alu          (alu),
    .mul_issue    (mul_issue),
    .icache_ready (icache_ready),
    .dcache_ready (dcache_ready),
    .pred_wrong   (pred_wrong),
    .xcpt         (xcpt),
    .stall        (stall),
    .flush        (flush)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] draw();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic chance(input int pct);
    return ((draw() >> 8) % 32'd100) < pct;  // low lcg bits are weak.
  endfunction

  task automatic add_test(input string name, input int cycles, input int imiss,
                          input int dmiss, input int load, input int match, input int mul,
                          input int taken, input int pred, input int xcpt_pct);
    test_cfg_t cfg;
    cfg = '{cycles, imiss, dmiss, load, match, mul, taken, pred, xcpt_pct};
    cfg_q.push_back(cfg);
    name_q.push_back(name);
  endtask

  task automatic drive_idle();
    dec             = '0;
    alu.rd          = '0;
    alu.result_src  = brisc_pkg::FROM_ALU;
    alu.pc_src      = brisc_pkg::FROM_F;
    mul_issue       = 1'b0;
    icache_ready    = 1'b1;
    dcache_ready    = 1'b1;
    pred_wrong      = 1'b0;
    xcpt            = brisc_pkg::NO_XCPT;
  endtask

  task automatic drive_random(input test_cfg_t cfg);
    logic [31:0] r;
    r = draw();
    dec.rs1 = r[4:0];
    dec.rs2 = r[9:5];
    alu.rd  = r[14:10];
    if (chance(cfg.load)) begin
      alu.result_src = brisc_pkg::FROM_CACHE;
    end else if (r[16:15] == 2'd1) begin
      alu.result_src = brisc_pkg::FROM_MUL;  // keep non-loads off FROM_CACHE.
    end else begin
      alu.result_src = brisc_pkg::result_src_e'(r[16:15]);
    end
    if (chance(cfg.match)) begin
      if (r[17]) begin
        dec.rs1 = alu.rd;
      end else begin
        dec.rs2 = alu.rd;
      end
    end
    alu.pc_src = chance(cfg.taken) ? brisc_pkg::FROM_A : brisc_pkg::FROM_F;
    xcpt = brisc_pkg::NO_XCPT;
    if (chance(cfg.xcpt)) begin
      xcpt = (r[19:18] == 2'd0) ? brisc_pkg::ILLEGAL_INSTR : brisc_pkg::xcpt_e'(r[19:18]);
    end
    mul_issue    = chance(cfg.mul);
    icache_ready = !chance(cfg.imiss);
    dcache_ready = !chance(cfg.dmiss);
    pred_wrong   = chance(cfg.pred);
  endtask

  task automatic run_test(input string name, input test_cfg_t cfg);
    i_chk.start_test(name);
    repeat (cfg.cycles) begin
      @(negedge clk);
      drive_random(cfg);
    end
    @(negedge clk);
    i_chk.end_test();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int limit;
    clk       = 1'b0;
    rst_n     = 1'b0;
    lcg_state = SEED;
    drive_idle();

    //        name               cyc  imis dmis load mtch  mul take pred xcpt
    add_test("reset_idle",        20,   0,   0,   0,   0,   0,   0,   0,   0);
    add_test("load_use",         200,   0,   0,  50,  50,   0,   0,   0,   0);
    add_test("mul_isolated",     200,   0,   0,   0,   0,  10,   0,   0,   0);
    add_test("mul_back_to_back", 200,   0,   0,   0,   0,  60,   0,   0,   0);
    add_test("icache_miss",      200,  40,   0,   0,   0,   0,   0,   0,   0);
    add_test("dcache_miss",      200,   0,  40,  50,  50,   0,  40,   0,   0);
    add_test("redirect",         200,   0,  20,   0,   0,   0,  50,  30,   0);
    add_test("exception",        200,   0,   0,  20,  30,   0,   0,   0,  30);
    add_test("random_mix",      2000,  50,  50,  50,  50,  50,  50,  50,  50);

    limit = RESET_CYCLES + WATCHDOG_MARGIN;
    foreach (cfg_q[i]) begin
      limit = limit + cfg_q[i].cycles + 1;  // one settling cycle per test.
    end
    limit = limit * CLK_PERIOD;

    fork
      begin
        #(limit);
        $display("watchdog: regression timed out after %0d ns", limit);
        $display("Regression failed");
        $finish;
      end
    join_none

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    foreach (cfg_q[i]) begin
      run_test(name_q[i], cfg_q[i]);
    end

    i_chk.report_counts();
    if (i_chk.total_errors == 0 && i_chk.tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/brisc_pkg.sv
design/pipe_ctrl_pkg.sv
design/load_use_check.sv
design/mul_tracker.sv
design/hazard.sv
design/pipe_ctrl_top.sv
verif/pipe_ctrl_checker.sv
verif/tb_pipe_ctrl.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   := verilog.f
TB_TOP     := tb_pipe_ctrl
RTL_TOP    := pipe_ctrl_top
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
